// ==== verilog.f ====
rtl/hni_pkg.sv
rtl/hni_rx_channel.sv
rtl/hni_data_buffer.sv
rtl/hni_mshr.sv
rtl/hni_tx_channel.sv
rtl/hni_top.sv
tb/hni_tb.sv

// ==== tb/hni_tb.sv ====
// Testbench for the CHI home node bridge
// CHI requester, AXI memory slave and a reference memory drive and check hni_top

`timescale 1ns/1ps

module hni_tb;
    import hni_pkg::*;

    localparam int N_RANDOM    = 40;
    localparam int N_TXN       = 2 + 6 + N_RANDOM;
    localparam int CYCLE_LIMIT = N_TXN * 60 + 200;

    logic      CLK = 1'b0;
    logic      RST = 1'b1;
    logic      rxreqflitv, rxdatflitv, txrsplcrdv, txdatlcrdv;
    logic      rxreqlcrdv, rxdatlcrdv, txrspflitv, txdatflitv;
    req_flit_t rxreqflit;
    dat_flit_t rxdatflit, txdatflit;
    rsp_flit_t txrspflit;
    mshr_idx_t arid, rid, awid, bid;
    addr_t     araddr, awaddr;
    data_t     rdata, wdata;
    logic      arvalid, arready, rvalid, rready, awvalid, awready;
    logic      wvalid, wready, bvalid, bready;

    logic [31:0] lfsr = 32'h605598bf;
    int cycle, errors, checks, tests, issued, done_cnt, rd_done, ar_count;
    int req_crd, dat_crd, rxreq_pulses, rxdat_pulses;
    int rsp_granted, dat_granted, rsp_flits, dat_flits;
    int tx_level = 3;       // 3 grants whenever there is room and 0 in one cycle of four
    logic ar_stall = 1'b0;
    data_t   slave_mem [64];
    data_t   ref_mem   [64];
    logic    addr_busy [64];
    logic    t_write [256];
    addr_t   t_addr  [256];
    nodeid_t t_src   [256];
    data_t   t_data  [256];
    int      t_stage [256];  // 1 issued, 2 DBID seen, 3 done
    int      t_dbid  [256];
    int      t_bbase [256];
    int      id_txn  [MSHR_ENTRIES];
    int      b_count [MSHR_ENTRIES];
    txnid_t    req_q[$];
    dat_flit_t dat_q[$];
    mshr_idx_t aw_q[$], r_id[$], b_id[$];
    addr_t     awa_q[$];
    data_t     w_q[$], r_dat[$];
    int        r_due[$], b_due[$];

    hni_top dut0 (.*);

    always #2 CLK = ~CLK;

    // Galois LFSR stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic data_t fill_word(input int i);
        return {32'hC0DE0000 | i, ~(i * 32'h9E3779B9)};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_error(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        $display("Test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "FAILED");
    endtask

    task automatic issue_txn(input logic write, input logic [5:0] idx);
        txnid_t t;
        while (addr_busy[idx]) @(posedge CLK);  // One access per word in flight
        t = txnid_t'(issued);
        t_write[t] = write;
        t_addr[t]  = {23'h0, idx, 3'b000};
        t_src[t]   = nodeid_t'(rand_bits(7));
        t_data[t]  = rand_bits(64);
        t_stage[t] = 1;
        addr_busy[idx] = 1'b1;
        issued++;
        req_q.push_back(t);
    endtask

    task automatic wait_idle();
        while (done_cnt < issued) @(posedge CLK);
    endtask

    function automatic void finish_txn(input txnid_t t);
        t_stage[t] = 3;
        addr_busy[t_addr[t][8:3]] = 1'b0;
        done_cnt++;
    endfunction

    // CHI requester and response monitor
    always @(posedge CLK) begin
        txnid_t t;
        if (!RST) begin
            req_crd += rxreqlcrdv;
            dat_crd += rxdatlcrdv;
            rxreq_pulses += rxreqlcrdv;
            rxdat_pulses += rxdatlcrdv;
        end
        rxreqflitv <= 1'b0;
        rxdatflitv <= 1'b0;
        if (req_q.size() > 0 && req_crd > 0) begin
            t = req_q.pop_front();
            rxreqflitv <= 1'b1;
            rxreqflit  <= '{srcid: t_src[t], txnid: t, addr: t_addr[t],
                            opcode: t_write[t] ? REQ_WRITE_NOSNP : REQ_READ_NOSNP};
            req_crd--;
        end
        if (dat_q.size() > 0 && dat_crd > 0) begin
            rxdatflitv <= 1'b1;
            rxdatflit  <= dat_q.pop_front();
            dat_crd--;
        end
        if (txrspflitv) begin
            rsp_flits++;
            t = txrspflit.txnid;
            check_value("txrspflit.tgtid", txrspflit.tgtid, t_src[t]);
            if (txrspflit.opcode == RSP_DBIDRESP) begin
                if (!(t_write[t] && t_stage[t] == 1)) begin
                    note_error($sformatf("unexpected DBIDResp for txnid %h", t));
                end else if (txrspflit.dbid >= MSHR_ENTRIES) begin
                    note_error($sformatf("DBIDResp dbid %h out of range", txrspflit.dbid));
                end else begin
                    t_stage[t] = 2;
                    t_dbid[t]  = txrspflit.dbid;
                    t_bbase[t] = b_count[txrspflit.dbid];
                    id_txn[txrspflit.dbid] = t;
                    dat_q.push_back(dat_flit_t'{tgtid: '0, txnid: txrspflit.dbid, dbid: '0,
                                    opcode: DAT_NONCOPYBACKWRDATA, data: t_data[t]});
                end
            end else if (!(t_write[t] && t_stage[t] == 2)) begin
                note_error($sformatf("unexpected Comp for txnid %h", t));
            end else begin
                check_value("txrspflit.opcode", txrspflit.opcode, RSP_COMP);
                check_value("txrspflit.dbid", txrspflit.dbid, t_dbid[t]);
                if (b_count[t_dbid[t]] <= t_bbase[t]) note_error("Comp arrived before B");
                ref_mem[t_addr[t][8:3]] = t_data[t];
                finish_txn(t);
            end
        end
        if (txdatflitv) begin
            dat_flits++;
            t = txdatflit.txnid;
            if (t_write[t] || t_stage[t] != 1) begin
                note_error($sformatf("unexpected CompData for txnid %h", t));
            end else begin
                check_value("txdatflit.opcode", txdatflit.opcode, DAT_COMPDATA);
                check_value("txdatflit.tgtid", txdatflit.tgtid, t_src[t]);
                check_value("txdatflit.data", txdatflit.data, ref_mem[t_addr[t][8:3]]);
                rd_done++;
                finish_txn(t);
            end
        end
        txrsplcrdv <= 1'b0;
        txdatlcrdv <= 1'b0;
        if (!RST && rsp_granted - rsp_flits < TX_CREDIT_MAX && rand_bits(2) <= tx_level) begin
            txrsplcrdv <= 1'b1;
            rsp_granted++;
        end
        if (!RST && dat_granted - dat_flits < TX_CREDIT_MAX && rand_bits(2) <= tx_level) begin
            txdatlcrdv <= 1'b1;
            dat_granted++;
        end
        if (rsp_flits > rsp_granted) note_error("TXRSP flit sent without a credit");
        if (dat_flits > dat_granted) note_error("TXDAT flit sent without a credit");
        if (ar_count - rd_done > MSHR_ENTRIES) note_error("more reads in flight than MSHR entries");
    end

    // AXI memory slave
    always @(posedge CLK) begin
        int pick;
        mshr_idx_t id;
        cycle++;
        if (!RST) begin
            if (rvalid) check_value("rready", rready, 1'b1);
            if (bvalid) check_value("bready", bready, 1'b1);
            if (arvalid && arready) begin
                ar_count++;
                r_id.push_back(arid);
                r_dat.push_back(slave_mem[araddr[8:3]]);
                r_due.push_back(cycle + int'(rand_bits(3) % 6));
            end
            if (awvalid && awready) begin
                check_value("awaddr", awaddr, t_addr[id_txn[awid]]);
                aw_q.push_back(awid);
                awa_q.push_back(awaddr);
            end
            if (wvalid && wready) w_q.push_back(wdata);
            if (aw_q.size() > 0 && w_q.size() > 0) begin    // W follows AW order
                id = aw_q.pop_front();
                check_value("wdata", w_q[0], t_data[id_txn[id]]);
                slave_mem[awa_q.pop_front() >> 3] = w_q.pop_front();
                b_id.push_back(id);
                b_due.push_back(cycle + int'(rand_bits(3) % 6));
            end
            rvalid <= 1'b0;
            pick = -1;
            foreach (r_due[i]) if (pick < 0 && r_due[i] <= cycle) pick = i;
            if (pick >= 0) begin
                rvalid <= 1'b1;
                rid    <= r_id[pick];
                rdata  <= r_dat[pick];
                r_id.delete(pick);
                r_dat.delete(pick);
                r_due.delete(pick);
            end
            bvalid <= 1'b0;
            pick = -1;
            foreach (b_due[i]) if (pick < 0 && b_due[i] <= cycle) pick = i;
            if (pick >= 0) begin
                bvalid <= 1'b1;
                bid    <= b_id[pick];
                b_count[b_id[pick]]++;
                b_id.delete(pick);
                b_due.delete(pick);
            end
            arready <= !ar_stall && rand_bits(1);
            awready <= 1'(rand_bits(1));
            wready  <= 1'(rand_bits(1));
        end
    end

    initial begin
        int err0;
        int pulses0;
        int n_wr;
        rxreqflitv = 1'b0;
        rxreqflit  = '0;
        rxdatflitv = 1'b0;
        rxdatflit  = '0;
        txrsplcrdv = 1'b0;
        txdatlcrdv = 1'b0;
        arready    = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        rvalid     = 1'b0;
        rid        = '0;
        rdata      = '0;
        bvalid     = 1'b0;
        bid        = '0;
        for (int i = 0; i < 64; i++) begin
            slave_mem[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
            addr_busy[i] = 1'b0;
        end
        repeat (3) @(posedge CLK);
        RST <= 1'b0;

        err0 = errors;
        repeat (20) @(posedge CLK);
        check_value("rxreqlcrdv pulses", rxreq_pulses, RX_DEPTH);
        check_value("rxdatlcrdv pulses", rxdat_pulses, RX_DEPTH);
        check_value("tx flit pulses", rsp_flits + dat_flits, 0);
        end_test("credits after reset", err0);

        err0 = errors;
        issue_txn(1'b1, 6'd5);
        wait_idle();
        issue_txn(1'b0, 6'd5);
        wait_idle();
        end_test("write then read", err0);

        // AR held off so four reads fill the MSHR and two wait in the queue
        err0 = errors;
        ar_stall = 1'b1;
        for (int i = 0; i < 6; i++) issue_txn(1'b0, 6'(8 + i));
        while (req_q.size() > 0) @(posedge CLK);
        pulses0 = rxreq_pulses;
        repeat (30) @(posedge CLK);
        check_value("rxreqlcrdv pulses while full", rxreq_pulses - pulses0, 0);
        check_value("requester credits while full", req_crd, 0);
        check_value("arvalid while stalled", arvalid, 1'b1);
        ar_stall = 1'b0;
        wait_idle();
        end_test("four outstanding", err0);

        err0 = errors;
        tx_level = 0;
        for (int i = 0; i < N_RANDOM; i++) begin
            issue_txn(1'(rand_bits(1)), 6'(rand_bits(4)));
            repeat (int'(rand_bits(2))) @(posedge CLK);
        end
        wait_idle();
        n_wr = 0;
        for (int i = 0; i < issued; i++) begin
            if (t_write[i]) n_wr++;
        end
        check_value("txrspflitv pulses", rsp_flits, 2 * n_wr);
        check_value("txdatflitv pulses", dat_flits, issued - n_wr);
        end_test("random traffic", err0);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== rtl/hni_top.sv ====
// Non-coherent CHI home node to AXI4 bridge
// RXREQ/RXDAT queues feed the MSHR and data buffer, TXRSP/TXDAT return responses

`timescale 1ns/1ps

module hni_top
    import hni_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,

    // CHI
    input  logic      rxreqflitv,
    input  req_flit_t rxreqflit,
    output logic      rxreqlcrdv,
    input  logic      rxdatflitv,
    input  dat_flit_t rxdatflit,
    output logic      rxdatlcrdv,
    output logic      txrspflitv,
    output rsp_flit_t txrspflit,
    input  logic      txrsplcrdv,
    output logic      txdatflitv,
    output dat_flit_t txdatflit,
    input  logic      txdatlcrdv,

    // AXI4
    output mshr_idx_t arid,
    output addr_t     araddr,
    output logic      arvalid,
    input  logic      arready,
    input  mshr_idx_t rid,
    input  data_t     rdata,
    input  logic      rvalid,
    output logic      rready,
    output mshr_idx_t awid,
    output addr_t     awaddr,
    output logic      awvalid,
    input  logic      awready,
    output data_t     wdata,
    output logic      wvalid,
    input  logic      wready,
    input  mshr_idx_t bid,
    input  logic      bvalid,
    output logic      bready
);

    logic                     req_valid, req_ready;
    req_flit_t                req_flit;
    logic                     dat_valid, dat_ready;
    dat_flit_t                dat_flit;
    logic [MSHR_ENTRIES-1:0]  slot_full;
    data_t [MSHR_ENTRIES-1:0] slot_data;
    logic                     clear_valid;
    mshr_idx_t                clear_idx;
    logic                     rsp_valid, rsp_ready;
    rsp_flit_t                rsp_flit;
    logic                     txdat_valid, txdat_ready;
    dat_flit_t                txdat_flit;

    assign rready = 1'b1;   // Every ID in flight owns a slot
    assign bready = 1'b1;

    hni_rx_channel #(.WIDTH($bits(req_flit_t))) u_rxreq (
        .CLK(CLK), .RST(RST), .flitv(rxreqflitv), .flit(rxreqflit), .lcrdv(rxreqlcrdv),
        .out_valid(req_valid), .out_flit(req_flit), .out_ready(req_ready));

    hni_rx_channel #(.WIDTH($bits(dat_flit_t))) u_rxdat (
        .CLK(CLK), .RST(RST), .flitv(rxdatflitv), .flit(rxdatflit), .lcrdv(rxdatlcrdv),
        .out_valid(dat_valid), .out_flit(dat_flit), .out_ready(dat_ready));

    hni_data_buffer u_data_buffer (
        .CLK(CLK), .RST(RST), .rdata(rdata), .rid(rid), .rvalid(rvalid),
        .dat_valid(dat_valid), .dat_flit(dat_flit), .dat_ready(dat_ready),
        .clear_valid(clear_valid), .clear_idx(clear_idx),
        .slot_full(slot_full), .slot_data(slot_data));

    hni_mshr u_mshr (
        .CLK(CLK), .RST(RST), .req_valid(req_valid), .req_flit(req_flit),
        .req_ready(req_ready), .slot_full(slot_full), .slot_data(slot_data),
        .clear_valid(clear_valid), .clear_idx(clear_idx),
        .rsp_valid(rsp_valid), .rsp_flit(rsp_flit), .rsp_ready(rsp_ready),
        .txdat_valid(txdat_valid), .txdat_flit(txdat_flit), .txdat_ready(txdat_ready),
        .arvalid(arvalid), .araddr(araddr), .arid(arid), .arready(arready),
        .rvalid(rvalid), .rid(rid), .awvalid(awvalid), .awaddr(awaddr), .awid(awid),
        .awready(awready), .wvalid(wvalid), .wdata(wdata), .wready(wready),
        .bvalid(bvalid), .bid(bid));

    hni_tx_channel #(.WIDTH($bits(rsp_flit_t))) u_txrsp (
        .CLK(CLK), .RST(RST), .lcrdv(txrsplcrdv), .in_valid(rsp_valid),
        .in_flit(rsp_flit), .in_ready(rsp_ready), .flitv(txrspflitv), .flit(txrspflit));

    hni_tx_channel #(.WIDTH($bits(dat_flit_t))) u_txdat (
        .CLK(CLK), .RST(RST), .lcrdv(txdatlcrdv), .in_valid(txdat_valid),
        .in_flit(txdat_flit), .in_ready(txdat_ready), .flitv(txdatflitv), .flit(txdatflit));

endmodule

// ==== rtl/hni_tx_channel.sv ====
// CHI transmit channel stage
// Tracks link credits from the receiver and registers one flit per credit

`timescale 1ns/1ps

module hni_tx_channel
    import hni_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic             CLK,
    input  logic             RST,
    input  logic             lcrdv,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_flit,
    output logic             in_ready,
    output logic             flitv,
    output logic [WIDTH-1:0] flit
);

    credit_t crd;
    logic    accept;

    assign in_ready = crd != '0;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge CLK) begin
        if (RST) begin
            crd   <= '0;
            flitv <= 1'b0;
        end else begin
            crd   <= crd + credit_t'(lcrdv) - credit_t'(accept);
            flitv <= accept;    // One cycle pulse per flit
        end
    end

    // Flit payload
    always_ff @(posedge CLK) begin
        if (accept) flit <= in_flit;
    end

    // Receiver must not grant beyond what the counter holds
    a_credit_limit: assert property (@(posedge CLK) disable iff (RST)
        (int'(crd) == TX_CREDIT_MAX && lcrdv) |-> accept);

endmodule

// ==== rtl/hni_mshr.sv ====
// Transaction table of the home node
// Allocates entries for ReadNoSnp/WriteNoSnp, drives AXI AR/AW/W
// and schedules DBIDResp, Comp and CompData towards the requester

`timescale 1ns/1ps

module hni_mshr
    import hni_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     req_valid,
    input  req_flit_t                req_flit,
    output logic                     req_ready,
    input  logic [MSHR_ENTRIES-1:0]  slot_full,
    input  data_t [MSHR_ENTRIES-1:0] slot_data,
    output logic                     clear_valid,
    output mshr_idx_t                clear_idx,
    output logic                     rsp_valid,
    output rsp_flit_t                rsp_flit,
    input  logic                     rsp_ready,
    output logic                     txdat_valid,
    output dat_flit_t                txdat_flit,
    input  logic                     txdat_ready,
    output logic                     arvalid,
    output addr_t                    araddr,
    output mshr_idx_t                arid,
    input  logic                     arready,
    input  logic                     rvalid,
    input  mshr_idx_t                rid,
    output logic                     awvalid,
    output addr_t                    awaddr,
    output mshr_idx_t                awid,
    input  logic                     awready,
    output logic                     wvalid,
    output data_t                    wdata,
    input  logic                     wready,
    input  logic                     bvalid,
    input  mshr_idx_t                bid
);

    mshr_state_t             state [MSHR_ENTRIES];
    nodeid_t                 srcid [MSHR_ENTRIES];
    txnid_t                  txnid [MSHR_ENTRIES];
    addr_t                   addr  [MSHR_ENTRIES];
    logic [MSHR_ENTRIES-1:0] aw_done, w_done;
    logic [MSHR_ENTRIES-1:0] idle_v, ar_v, wr_v, rsp_v, dat_v;
    mshr_idx_t               alloc_idx, ar_idx, wr_idx, rsp_idx, dat_idx;
    logic                    ar_hold, wr_hold, rsp_hold, dat_hold;
    mshr_idx_t               ar_hold_idx, wr_hold_idx, rsp_hold_idx, dat_hold_idx;
    logic                    alloc_fire, ar_fire, aw_fire, w_fire, rsp_fire, dat_fire;
    logic                    wr_finish;

    function automatic mshr_idx_t first_set(input logic [MSHR_ENTRIES-1:0] vec);
        mshr_idx_t idx;
        idx = '0;
        for (int i = MSHR_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) idx = mshr_idx_t'(i);
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < MSHR_ENTRIES; i++) begin
            idle_v[i] = state[i] == IDLE;
            ar_v[i]   = state[i] == READ_ADDR;
            wr_v[i]   = state[i] == WRITE_ISSUE;
            rsp_v[i]  = (state[i] == SEND_DBID) || (state[i] == SEND_COMP);
            dat_v[i]  = state[i] == SEND_DATA;
        end
        // Lowest index wins, a stalled winner keeps its grant
        alloc_idx = first_set(idle_v);
        ar_idx    = ar_hold  ? ar_hold_idx  : first_set(ar_v);
        wr_idx    = wr_hold  ? wr_hold_idx  : first_set(wr_v);
        rsp_idx   = rsp_hold ? rsp_hold_idx : first_set(rsp_v);
        dat_idx   = dat_hold ? dat_hold_idx : first_set(dat_v);
    end

    assign req_ready  = |idle_v;
    assign alloc_fire = req_valid && req_ready;
    assign clear_valid = alloc_fire;    // Slot emptied as the entry is taken
    assign clear_idx   = alloc_idx;

    assign arvalid = |ar_v;
    assign araddr  = addr[ar_idx];
    assign arid    = ar_idx;
    assign ar_fire = arvalid && arready;

    assign awvalid   = |wr_v && !aw_done[wr_idx];
    assign wvalid    = |wr_v && !w_done[wr_idx];
    assign awaddr    = addr[wr_idx];
    assign awid      = wr_idx;
    assign wdata     = slot_data[wr_idx];
    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign wr_finish = |wr_v && (aw_done[wr_idx] || aw_fire) && (w_done[wr_idx] || w_fire);

    assign rsp_valid       = |rsp_v;
    assign rsp_flit.tgtid  = srcid[rsp_idx];
    assign rsp_flit.txnid  = txnid[rsp_idx];
    assign rsp_flit.opcode = (state[rsp_idx] == SEND_COMP) ? RSP_COMP : RSP_DBIDRESP;
    assign rsp_flit.dbid   = txnid_t'(rsp_idx);
    assign rsp_fire        = rsp_valid && rsp_ready;

    assign txdat_valid       = |dat_v;
    assign txdat_flit.tgtid  = srcid[dat_idx];
    assign txdat_flit.txnid  = txnid[dat_idx];
    assign txdat_flit.opcode = DAT_COMPDATA;
    assign txdat_flit.dbid   = txnid_t'(dat_idx);
    assign txdat_flit.data   = slot_data[dat_idx];
    assign dat_fire          = txdat_valid && txdat_ready;

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < MSHR_ENTRIES; i++) state[i] <= IDLE;
            aw_done  <= '0;
            w_done   <= '0;
            ar_hold  <= 1'b0;
            wr_hold  <= 1'b0;
            rsp_hold <= 1'b0;
            dat_hold <= 1'b0;
        end else begin
            ar_hold      <= arvalid && !arready;
            wr_hold      <= |wr_v && !wr_finish;   // Keeps AW/W order on AXI
            rsp_hold     <= rsp_valid && !rsp_ready;
            dat_hold     <= txdat_valid && !txdat_ready;
            ar_hold_idx  <= ar_idx;
            wr_hold_idx  <= wr_idx;
            rsp_hold_idx <= rsp_idx;
            dat_hold_idx <= dat_idx;
            for (int i = 0; i < MSHR_ENTRIES; i++) begin
                case (state[i])
                    IDLE: if (alloc_fire && alloc_idx == i) begin
                        state[i]   <= (req_flit.opcode == REQ_WRITE_NOSNP) ? SEND_DBID
                                                                           : READ_ADDR;
                        aw_done[i] <= 1'b0;
                        w_done[i]  <= 1'b0;
                    end
                    READ_ADDR: if (ar_fire && ar_idx == i) state[i] <= READ_WAIT;
                    READ_WAIT: if (slot_full[i]) state[i] <= SEND_DATA;
                    SEND_DATA: if (dat_fire && dat_idx == i) state[i] <= IDLE;
                    SEND_DBID: if (rsp_fire && rsp_idx == i) state[i] <= WRITE_DATA_WAIT;
                    WRITE_DATA_WAIT: if (slot_full[i]) state[i] <= WRITE_ISSUE;
                    WRITE_ISSUE: if (wr_idx == i) begin
                        if (aw_fire) aw_done[i] <= 1'b1;
                        if (w_fire) w_done[i] <= 1'b1;
                        if (wr_finish) state[i] <= WRITE_RESP_WAIT;
                    end
                    WRITE_RESP_WAIT: if (bvalid && bid == i) state[i] <= SEND_COMP;
                    SEND_COMP: if (rsp_fire && rsp_idx == i) state[i] <= IDLE;
                    default: state[i] <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (alloc_fire) begin
            srcid[alloc_idx] <= req_flit.srcid;
            txnid[alloc_idx] <= req_flit.txnid;
            addr[alloc_idx]  <= req_flit.addr;
        end
    end

    // AXI responses only for IDs with an outstanding access
    a_rid_owned: assert property (@(posedge CLK) disable iff (RST)
        rvalid |-> state[rid] == READ_WAIT);
    a_bid_owned: assert property (@(posedge CLK) disable iff (RST)
        bvalid |-> state[bid] == WRITE_RESP_WAIT);

endmodule

// ==== rtl/hni_data_buffer.sv ====
// Per-entry data slots for the MSHR
// Filled by AXI read data or CHI write data, one write per cycle

`timescale 1ns/1ps

module hni_data_buffer
    import hni_pkg::*;
(
    input  logic                         CLK,
    input  logic                         RST,

    // AXI read data
    input  data_t                        rdata,
    input  mshr_idx_t                    rid,
    input  logic                         rvalid,

    // CHI write data
    input  logic                         dat_valid,
    input  dat_flit_t                    dat_flit,
    output logic                         dat_ready,

    // MSHR side
    input  logic                         clear_valid,
    input  mshr_idx_t                    clear_idx,
    output logic [MSHR_ENTRIES-1:0]      slot_full,
    output data_t [MSHR_ENTRIES-1:0]     slot_data
);

    logic      wr_en;
    mshr_idx_t wr_idx;
    data_t     wr_data;

    assign dat_ready = !rvalid;  // R beat owns the write port

    always_comb begin
        wr_en = rvalid || dat_valid;
        if (rvalid) begin
            wr_idx  = rid;
            wr_data = rdata;
        end else begin
            wr_idx  = mshr_idx_t'(dat_flit.txnid);   // txnid carries the DBID
            wr_data = dat_flit.data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            slot_full <= '0;
        end else begin
            if (clear_valid) slot_full[clear_idx] <= 1'b0;
            if (wr_en) slot_full[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) slot_data[wr_idx] <= wr_data;
    end

    // A slot is filled once per transaction
    a_no_overwrite: assert property (@(posedge CLK) disable iff (RST)
        wr_en |-> !slot_full[wr_idx]);

endmodule

// ==== rtl/hni_rx_channel.sv ====
// CHI receive channel queue
// Buffers incoming flits and hands out link credits as space frees up

`timescale 1ns/1ps

module hni_rx_channel
    import hni_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic             CLK,
    input  logic             RST,
    input  logic             flitv,
    input  logic [WIDTH-1:0] flit,
    output logic             lcrdv,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_flit,
    input  logic             out_ready
);

    localparam int PTR_W = $clog2(RX_DEPTH);
    localparam int CNT_W = $clog2(RX_DEPTH + 1);

    logic [WIDTH-1:0] mem [RX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_n;
    logic [CNT_W-1:0] crd;      // Credits granted, flit not yet seen
    logic [CNT_W-1:0] crd_n;
    logic             pop;
    logic             grant;

    assign pop       = out_valid && out_ready;
    assign out_valid = count != '0;
    assign out_flit  = mem[rd_ptr];

    always_comb begin
        count_n = count + CNT_W'(flitv) - CNT_W'(pop);
        crd_n   = crd - CNT_W'(flitv);
        grant   = (int'(crd_n) + int'(count_n)) < RX_DEPTH;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            crd    <= '0;
            lcrdv  <= 1'b0;
        end else begin
            if (flitv) begin
                wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_n;
            crd   <= crd_n + CNT_W'(grant);
            lcrdv <= grant;
        end
    end

    always_ff @(posedge CLK) begin
        if (flitv) mem[wr_ptr] <= flit;
    end

    // Sender must only use credits it was given
    a_no_overrun: assert property (@(posedge CLK) disable iff (RST)
        flitv |-> (int'(count) < RX_DEPTH));

endmodule

// ==== rtl/hni_pkg.sv ====
// Shared definitions for the non-coherent CHI home node bridge
// Sizes, plain vector types, opcodes and the CHI flit layouts

package hni_pkg;

    localparam int MSHR_ENTRIES  = 4;   // Transactions in flight
    localparam int RX_DEPTH      = 2;   // Receive queue depth and granted link credits
    localparam int TX_CREDIT_MAX = 15;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  txnid_t;
    typedef logic [6:0]  nodeid_t;
    typedef logic [1:0]  mshr_idx_t;    // Also AXI ID and DBID
    typedef logic [3:0]  credit_t;

    typedef enum logic [6:0] {
        REQ_READ_NOSNP  = 7'h04,
        REQ_WRITE_NOSNP = 7'h1D
    } req_opcode_t;

    typedef enum logic [4:0] {
        RSP_COMP     = 5'h04,
        RSP_DBIDRESP = 5'h06
    } rsp_opcode_t;

    typedef enum logic [3:0] {
        DAT_NONCOPYBACKWRDATA = 4'h3,
        DAT_COMPDATA          = 4'h4
    } dat_opcode_t;

    typedef enum logic [3:0] {
        IDLE,
        READ_ADDR,
        READ_WAIT,
        SEND_DATA,
        SEND_DBID,
        WRITE_DATA_WAIT,
        WRITE_ISSUE,
        WRITE_RESP_WAIT,
        SEND_COMP
    } mshr_state_t;

    typedef struct packed {
        nodeid_t     srcid;
        txnid_t      txnid;
        req_opcode_t opcode;
        addr_t       addr;
    } req_flit_t;

    typedef struct packed {
        nodeid_t     tgtid;
        txnid_t      txnid;
        rsp_opcode_t opcode;
        txnid_t      dbid;
    } rsp_flit_t;

    typedef struct packed {
        nodeid_t     tgtid;
        txnid_t      txnid;
        dat_opcode_t opcode;
        txnid_t      dbid;
        data_t       data;
    } dat_flit_t;

endpackage
